//--- common/axi_ram_pkg.sv
package axi_ram_pkg;

  // bus geometry
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int STRB_W = DATA_W / 8;
  localparam int ID_W   = 4;

  localparam int BYTE_OFFS_W = $clog2(STRB_W);  // byte bits below the word index

  localparam logic [1:0] RESP_OKAY   = 2'd0;
  localparam logic [1:0] RESP_SLVERR = 2'd2;

  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [ADDR_W-1:0] addr;
  } aw_chan_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
  } w_chan_t;

  typedef struct packed {
    logic [ID_W-1:0] id;
    logic [1:0]      resp;
  } b_chan_t;

  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [ADDR_W-1:0] addr;
  } ar_chan_t;

  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [DATA_W-1:0] data;
    logic [1:0]        resp;
  } r_chan_t;

  // master to slave
  typedef struct packed {
    aw_chan_t aw;
    logic     aw_valid;
    w_chan_t  w;
    logic     w_valid;
    logic     b_ready;
    ar_chan_t ar;
    logic     ar_valid;
    logic     r_ready;
  } req_t;

  // slave to master
  typedef struct packed {
    logic     aw_ready;
    logic     w_ready;
    b_chan_t  b;
    logic     b_valid;
    logic     ar_ready;
    r_chan_t  r;
    logic     r_valid;
  } resp_t;

endpackage

//--- hdl/chan_fifo.sv
`timescale 1ns/1ps

module chan_fifo #(
  parameter type chan_t = logic,
  parameter int  DEPTH  = 2
) (
  input  logic  clk_i,
  input  logic  arst_ni,
  input  chan_t in_i,
  input  logic  in_valid_i,
  output logic  in_ready_o,
  output chan_t out_o,
  output logic  out_valid_o,
  input  logic  out_ready_i
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  chan_t             mem_q [DEPTH];
  logic [PTR_W-1:0]  wr_ptr_q, rd_ptr_q;
  logic [CNT_W-1:0]  cnt_q;
  logic              push, pop;

  assign in_ready_o  = (cnt_q != CNT_W'(DEPTH));
  assign out_valid_o = (cnt_q != '0);
  assign out_o       = mem_q[rd_ptr_q];

  assign push = in_valid_i & in_ready_o;
  assign pop  = out_valid_o & out_ready_i;

  always_ff @(posedge clk_i or negedge arst_ni) begin
    if (!arst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push && !pop) cnt_q <= cnt_q + 1'b1;
      else if (pop && !push) cnt_q <= cnt_q - 1'b1;  // push and pop together keep the count
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) mem_q[wr_ptr_q] <= in_i;
  end

endmodule

//--- hdl/mem_bank.sv
`timescale 1ns/1ps

module mem_bank #(
  parameter int MEM_SIZE = 12
) (
  input  logic                                            clk_i,
  input  logic                                            arst_ni,
  input  logic                                            req_i,
  input  logic                                            we_i,
  input  logic [MEM_SIZE-axi_ram_pkg::BYTE_OFFS_W-1:0]    addr_i,
  input  logic [axi_ram_pkg::DATA_W-1:0]                  wdata_i,
  input  logic [axi_ram_pkg::STRB_W-1:0]                  strb_i,
  output logic [axi_ram_pkg::DATA_W-1:0]                  rdata_o
);

  import axi_ram_pkg::*;

  localparam int WORDS = 2 ** (MEM_SIZE - BYTE_OFFS_W);

  logic [DATA_W-1:0] mem_q [WORDS];

  // byte lane writes
  always_ff @(posedge clk_i) begin
    if (req_i && we_i) begin
      for (int i = 0; i < STRB_W; i++) begin
        if (strb_i[i]) mem_q[addr_i][8*i +: 8] <= wdata_i[8*i +: 8];
      end
    end
  end

  // read data lands one cycle after the request
  always_ff @(posedge clk_i or negedge arst_ni) begin
    if (!arst_ni) begin
      rdata_o <= '0;
    end else if (req_i && !we_i) begin
      rdata_o <= mem_q[addr_i];
    end
  end

endmodule

//--- axi_to_mem/axi_to_mem.sv
`timescale 1ns/1ps

module axi_to_mem #(
  parameter logic [axi_ram_pkg::ADDR_W-1:0] MEM_BASE     = 32'h1000,
  parameter int                             MEM_SIZE     = 12,
  parameter bit                             ALLOW_WRITES = 1'b1
) (
  input  logic                                          clk_i,
  input  logic                                          arst_ni,
  // request side, from the input FIFOs
  input  axi_ram_pkg::aw_chan_t                         aw_i,
  input  logic                                          aw_valid_i,
  output logic                                          aw_ready_o,
  input  axi_ram_pkg::w_chan_t                          w_i,
  input  logic                                          w_valid_i,
  output logic                                          w_ready_o,
  input  axi_ram_pkg::ar_chan_t                         ar_i,
  input  logic                                          ar_valid_i,
  output logic                                          ar_ready_o,
  // response side, into the output FIFOs
  output axi_ram_pkg::b_chan_t                          b_o,
  output logic                                          b_valid_o,
  input  logic                                          b_ready_i,
  output axi_ram_pkg::r_chan_t                          r_o,
  output logic                                          r_valid_o,
  input  logic                                          r_ready_i,
  // memory port
  output logic                                          mem_req_o,
  output logic                                          mem_we_o,
  output logic [MEM_SIZE-axi_ram_pkg::BYTE_OFFS_W-1:0]  mem_addr_o,
  output logic [axi_ram_pkg::DATA_W-1:0]                mem_wdata_o,
  output logic [axi_ram_pkg::STRB_W-1:0]                mem_strb_o,
  input  logic [axi_ram_pkg::DATA_W-1:0]                mem_rdata_i
);

  import axi_ram_pkg::*;

  typedef enum logic {
    ST_IDLE,
    ST_RESP
  } state_e;

  state_e            state_q, state_d;
  logic              is_wr_q;
  logic              err_q;
  logic [ID_W-1:0]   id_q;

  logic [ADDR_W-1:0] wr_offs, rd_offs;
  logic              wr_in_win, rd_in_win;
  logic              wr_err;
  logic              start_wr, start_rd;
  logic              resp_done;

  // offsets into the window
  assign wr_offs   = aw_i.addr - MEM_BASE;
  assign rd_offs   = ar_i.addr - MEM_BASE;
  assign wr_in_win = (wr_offs[ADDR_W-1:MEM_SIZE] == '0);
  assign rd_in_win = (rd_offs[ADDR_W-1:MEM_SIZE] == '0);
  assign wr_err    = !wr_in_win || !ALLOW_WRITES;

  // writes win over reads
  assign start_wr = (state_q == ST_IDLE) && aw_valid_i && w_valid_i;
  assign start_rd = (state_q == ST_IDLE) && !(aw_valid_i && w_valid_i) && ar_valid_i;

  assign aw_ready_o = start_wr;
  assign w_ready_o  = start_wr;
  assign ar_ready_o = start_rd;

  // failing accesses never reach the bank
  assign mem_req_o   = (start_wr && !wr_err) || (start_rd && rd_in_win);
  assign mem_we_o    = start_wr;
  assign mem_addr_o  = start_wr ? wr_offs[MEM_SIZE-1:BYTE_OFFS_W]
                                : rd_offs[MEM_SIZE-1:BYTE_OFFS_W];
  assign mem_wdata_o = w_i.data;
  assign mem_strb_o  = w_i.strb;

  assign b_o.id      = id_q;
  assign b_o.resp    = err_q ? RESP_SLVERR : RESP_OKAY;
  assign b_valid_o   = (state_q == ST_RESP) && is_wr_q;

  assign r_o.id      = id_q;
  assign r_o.data    = err_q ? '0 : mem_rdata_i;  // bank output holds while waiting
  assign r_o.resp    = err_q ? RESP_SLVERR : RESP_OKAY;
  assign r_valid_o   = (state_q == ST_RESP) && !is_wr_q;

  assign resp_done = is_wr_q ? b_ready_i : r_ready_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: if (start_wr || start_rd) state_d = ST_RESP;
      ST_RESP: if (resp_done) state_d = ST_IDLE;
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_ni) begin
    if (!arst_ni) begin
      state_q <= ST_IDLE;
      is_wr_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (start_wr || start_rd) is_wr_q <= start_wr;
    end
  end

  // id and error flag kept for the response
  always_ff @(posedge clk_i) begin
    if (start_wr) begin
      id_q  <= aw_i.id;
      err_q <= wr_err;
    end else if (start_rd) begin
      id_q  <= ar_i.id;
      err_q <= !rd_in_win;
    end
  end

endmodule

//--- hdl/axi_ram.sv
`timescale 1ns/1ps

module axi_ram #(
  parameter logic [axi_ram_pkg::ADDR_W-1:0] MEM_BASE     = 32'h1000,
  parameter int                             MEM_SIZE     = 12,
  parameter bit                             ALLOW_WRITES = 1'b1,
  parameter int                             FIFO_DEPTH   = 2
) (
  input  logic               clk_i,
  input  logic               arst_ni,
  input  axi_ram_pkg::req_t  req_i,
  output axi_ram_pkg::resp_t resp_o
);

  import axi_ram_pkg::*;

  // converter side of the channel FIFOs
  aw_chan_t aw;
  logic     aw_valid, aw_ready;
  w_chan_t  w;
  logic     w_valid, w_ready;
  ar_chan_t ar;
  logic     ar_valid, ar_ready;
  b_chan_t  b;
  logic     b_valid, b_ready;
  r_chan_t  r;
  logic     r_valid, r_ready;

  logic                              mem_req, mem_we;
  logic [MEM_SIZE-BYTE_OFFS_W-1:0]   mem_addr;
  logic [DATA_W-1:0]                 mem_wdata, mem_rdata;
  logic [STRB_W-1:0]                 mem_strb;

  chan_fifo #(.chan_t(aw_chan_t), .DEPTH(FIFO_DEPTH)) i_aw_fifo (
    .clk_i      (clk_i),
    .arst_ni    (arst_ni),
    .in_i       (req_i.aw),
    .in_valid_i (req_i.aw_valid),
    .in_ready_o (resp_o.aw_ready),
    .out_o      (aw),
    .out_valid_o(aw_valid),
    .out_ready_i(aw_ready)
  );

  chan_fifo #(.chan_t(w_chan_t), .DEPTH(FIFO_DEPTH)) i_w_fifo (
    .clk_i      (clk_i),
    .arst_ni    (arst_ni),
    .in_i       (req_i.w),
    .in_valid_i (req_i.w_valid),
    .in_ready_o (resp_o.w_ready),
    .out_o      (w),
    .out_valid_o(w_valid),
    .out_ready_i(w_ready)
  );

  chan_fifo #(.chan_t(ar_chan_t), .DEPTH(FIFO_DEPTH)) i_ar_fifo (
    .clk_i      (clk_i),
    .arst_ni    (arst_ni),
    .in_i       (req_i.ar),
    .in_valid_i (req_i.ar_valid),
    .in_ready_o (resp_o.ar_ready),
    .out_o      (ar),
    .out_valid_o(ar_valid),
    .out_ready_i(ar_ready)
  );

  chan_fifo #(.chan_t(b_chan_t), .DEPTH(FIFO_DEPTH)) i_b_fifo (
    .clk_i      (clk_i),
    .arst_ni    (arst_ni),
    .in_i       (b),
    .in_valid_i (b_valid),
    .in_ready_o (b_ready),
    .out_o      (resp_o.b),
    .out_valid_o(resp_o.b_valid),
    .out_ready_i(req_i.b_ready)
  );

  chan_fifo #(.chan_t(r_chan_t), .DEPTH(FIFO_DEPTH)) i_r_fifo (
    .clk_i      (clk_i),
    .arst_ni    (arst_ni),
    .in_i       (r),
    .in_valid_i (r_valid),
    .in_ready_o (r_ready),
    .out_o      (resp_o.r),
    .out_valid_o(resp_o.r_valid),
    .out_ready_i(req_i.r_ready)
  );

  axi_to_mem #(
    .MEM_BASE    (MEM_BASE),
    .MEM_SIZE    (MEM_SIZE),
    .ALLOW_WRITES(ALLOW_WRITES)
  ) i_conv (
    .clk_i      (clk_i),
    .arst_ni    (arst_ni),
    .aw_i       (aw),
    .aw_valid_i (aw_valid),
    .aw_ready_o (aw_ready),
    .w_i        (w),
    .w_valid_i  (w_valid),
    .w_ready_o  (w_ready),
    .ar_i       (ar),
    .ar_valid_i (ar_valid),
    .ar_ready_o (ar_ready),
    .b_o        (b),
    .b_valid_o  (b_valid),
    .b_ready_i  (b_ready),
    .r_o        (r),
    .r_valid_o  (r_valid),
    .r_ready_i  (r_ready),
    .mem_req_o  (mem_req),
    .mem_we_o   (mem_we),
    .mem_addr_o (mem_addr),
    .mem_wdata_o(mem_wdata),
    .mem_strb_o (mem_strb),
    .mem_rdata_i(mem_rdata)
  );

  mem_bank #(.MEM_SIZE(MEM_SIZE)) i_bank (
    .clk_i  (clk_i),
    .arst_ni(arst_ni),
    .req_i  (mem_req),
    .we_i   (mem_we),
    .addr_i (mem_addr),
    .wdata_i(mem_wdata),
    .strb_i (mem_strb),
    .rdata_o(mem_rdata)
  );

endmodule

//--- bench/axi_ram_assert.sv
`timescale 1ns/1ps

module axi_ram_assert (
  input logic               clk_i,
  input logic               arst_ni,
  input axi_ram_pkg::req_t  req_i,
  input axi_ram_pkg::resp_t resp_i
);

  import axi_ram_pkg::*;

  logic [7:0] wr_open, rd_open;  // accepted requests still waiting for a response
  int         b_hold_fails = 0;
  int         r_hold_fails = 0;
  int         b_orphan_fails = 0;
  int         r_orphan_fails = 0;
  int         fail_cnt;

  assign fail_cnt = b_hold_fails + r_hold_fails + b_orphan_fails + r_orphan_fails;

  always_ff @(posedge clk_i or negedge arst_ni) begin
    if (!arst_ni) begin
      wr_open <= '0;
      rd_open <= '0;
    end else begin
      if ((req_i.aw_valid && resp_i.aw_ready) && !(resp_i.b_valid && req_i.b_ready)) begin
        wr_open <= wr_open + 8'd1;
      end else if (!(req_i.aw_valid && resp_i.aw_ready) && (resp_i.b_valid && req_i.b_ready)) begin
        wr_open <= wr_open - 8'd1;
      end
      if ((req_i.ar_valid && resp_i.ar_ready) && !(resp_i.r_valid && req_i.r_ready)) begin
        rd_open <= rd_open + 8'd1;
      end else if (!(req_i.ar_valid && resp_i.ar_ready) && (resp_i.r_valid && req_i.r_ready)) begin
        rd_open <= rd_open - 8'd1;
      end
    end
  end

  b_hold: assert property (@(posedge clk_i) disable iff (!arst_ni)
    resp_i.b_valid && !req_i.b_ready |=> resp_i.b_valid && $stable(resp_i.b))
    else begin
      $error("B valid dropped or payload changed before its handshake");
      b_hold_fails++;
    end

  r_hold: assert property (@(posedge clk_i) disable iff (!arst_ni)
    resp_i.r_valid && !req_i.r_ready |=> resp_i.r_valid && $stable(resp_i.r))
    else begin
      $error("R valid dropped or payload changed before its handshake");
      r_hold_fails++;
    end

  b_orphan: assert property (@(posedge clk_i) disable iff (!arst_ni)
    resp_i.b_valid |-> wr_open != '0)
    else begin
      $error("B response without an accepted write");
      b_orphan_fails++;
    end

  r_orphan: assert property (@(posedge clk_i) disable iff (!arst_ni)
    resp_i.r_valid |-> rd_open != '0)
    else begin
      $error("R response without an accepted read");
      r_orphan_fails++;
    end

endmodule

bind axi_ram axi_ram_assert i_assert (
  .clk_i  (clk_i),
  .arst_ni(arst_ni),
  .req_i  (req_i),
  .resp_i (resp_o)
);

//--- bench/tb_axi_ram.sv
`timescale 1ns/1ps

module tb_axi_ram;

  import axi_ram_pkg::*;

  localparam logic [ADDR_W-1:0] MEM_BASE     = 32'h1000;
  localparam int                MEM_SIZE     = 12;
  localparam bit                ALLOW_WRITES = 1'b1;
  localparam int                TIMEOUT      = 200;
  localparam int                N_ROWS       = 16;

  typedef struct packed {
    logic              wr;
    logic [ID_W-1:0]   id;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [STRB_W-1:0] strb;
    logic [1:0]        resp;  // expected response code
  } row_t;

  logic     clk = 1'b0;
  logic     arst_n;
  req_t     req;
  resp_t    resp;
  aw_chan_t aw;
  logic     aw_valid;
  w_chan_t  w;
  logic     w_valid;
  ar_chan_t ar;
  logic     ar_valid;
  logic     b_ready;
  logic     r_ready;

  row_t        rows [N_ROWS];
  logic [7:0]  model_mem [2**MEM_SIZE];  // byte image of the window
  int          err_cnt = 0;
  int          chk_cnt = 0;
  bit          abort = 1'b0;
  int          seed = 32'h815f;
  logic [31:0] rnd;

  assign req.aw       = aw;
  assign req.aw_valid = aw_valid;
  assign req.w        = w;
  assign req.w_valid  = w_valid;
  assign req.b_ready  = b_ready;
  assign req.ar       = ar;
  assign req.ar_valid = ar_valid;
  assign req.r_ready  = r_ready;

  axi_ram #(
    .MEM_BASE    (MEM_BASE),
    .MEM_SIZE    (MEM_SIZE),
    .ALLOW_WRITES(ALLOW_WRITES),
    .FIFO_DEPTH  (2)
  ) i_dut (
    .clk_i  (clk),
    .arst_ni(arst_n),
    .req_i  (req),
    .resp_o (resp)
  );

  always #4 clk = ~clk;

  // random back-pressure on B and R
  initial begin
    b_ready <= 1'b0;
    r_ready <= 1'b0;
    forever begin
      @(posedge clk);
      rnd = $random(seed);
      b_ready <= rnd[0];
      r_ready <= rnd[1];
    end
  end

  function automatic bit in_window(logic [ADDR_W-1:0] addr);
    logic [ADDR_W-1:0] offs;
    offs = addr - MEM_BASE;
    return offs < (32'd1 << MEM_SIZE);
  endfunction

  function automatic logic [DATA_W-1:0] model_read(logic [ADDR_W-1:0] addr);
    logic [ADDR_W-1:0] offs;
    logic [DATA_W-1:0] data;
    data = '0;  // out of window reads return zero
    offs = addr - MEM_BASE;
    if (in_window(addr)) begin
      for (int i = 0; i < STRB_W; i++) begin
        data[8*i +: 8] = model_mem[{offs[MEM_SIZE-1:BYTE_OFFS_W], BYTE_OFFS_W'(i)}];
      end
    end
    return data;
  endfunction

  task automatic model_write(row_t r);
    logic [ADDR_W-1:0] offs;
    offs = r.addr - MEM_BASE;
    if (ALLOW_WRITES && in_window(r.addr)) begin
      for (int i = 0; i < STRB_W; i++) begin
        if (r.strb[i]) model_mem[{offs[MEM_SIZE-1:BYTE_OFFS_W], BYTE_OFFS_W'(i)}] = r.wdata[8*i +: 8];
      end
    end
  endtask

  task automatic compare(string name, logic [63:0] got, logic [63:0] exp);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
    end
  endtask

  // drive AW and W, or AR, until every channel of the row is accepted
  task automatic send_req(row_t r);
    int n;
    bit a_done;
    bit d_done;
    n = 0;
    a_done = 1'b0;
    d_done = !r.wr;
    if (r.wr) begin
      aw       <= '{id: r.id, addr: r.addr};
      aw_valid <= 1'b1;
      w        <= '{data: r.wdata, strb: r.strb};
      w_valid  <= 1'b1;
    end else begin
      ar       <= '{id: r.id, addr: r.addr};
      ar_valid <= 1'b1;
    end
    while (!(a_done && d_done) && n < TIMEOUT) begin
      @(posedge clk);
      n++;
      if (aw_valid && resp.aw_ready) begin
        a_done = 1'b1;
        aw_valid <= 1'b0;
      end
      if (w_valid && resp.w_ready) begin
        d_done = 1'b1;
        w_valid <= 1'b0;
      end
      if (ar_valid && resp.ar_ready) begin
        a_done = 1'b1;
        ar_valid <= 1'b0;
      end
    end
    if (!(a_done && d_done)) begin
      $display("timeout: request with id %0d was never accepted", r.id);
      err_cnt++;
      abort = 1'b1;
    end
  endtask

  task automatic wait_resp(row_t r, logic [DATA_W-1:0] exp_data);
    int n;
    bit seen;
    n = 0;
    seen = 1'b0;
    while (!seen && n < TIMEOUT) begin
      @(posedge clk);
      n++;
      if (r.wr && resp.b_valid && b_ready) begin
        seen = 1'b1;
        compare("b.id", 64'(resp.b.id), 64'(r.id));
        compare("b.resp", 64'(resp.b.resp), 64'(r.resp));
      end else if (!r.wr && resp.r_valid && r_ready) begin
        seen = 1'b1;
        compare("r.id", 64'(resp.r.id), 64'(r.id));
        compare("r.resp", 64'(resp.r.resp), 64'(r.resp));
        compare("r.data", 64'(resp.r.data), 64'(exp_data));
      end
    end
    if (!seen) begin
      $display("timeout: no response arrived for id %0d", r.id);
      err_cnt++;
      abort = 1'b1;
    end
  endtask

  initial begin
    logic [DATA_W-1:0] exp_data;
    int                assert_fails;
    aw       <= '0;
    aw_valid <= 1'b0;
    w        <= '0;
    w_valid  <= 1'b0;
    ar       <= '0;
    ar_valid <= 1'b0;
    arst_n   <= 1'b0;

    // wr, id, addr, wdata, strb, expected resp
    rows[0]  = '{1'b1, 4'd1,  32'h1010, 32'h1122_3344, 4'hf,    RESP_OKAY};
    rows[1]  = '{1'b0, 4'd2,  32'h1010, 32'h0,         4'h0,    RESP_OKAY};
    rows[2]  = '{1'b1, 4'd3,  32'h1014, 32'ha5a5_a5a5, 4'hf,    RESP_OKAY};
    rows[3]  = '{1'b1, 4'd4,  32'h1014, 32'h0000_be00, 4'b0010, RESP_OKAY};
    rows[4]  = '{1'b0, 4'd5,  32'h1014, 32'h0,         4'h0,    RESP_OKAY};
    rows[5]  = '{1'b1, 4'd6,  32'h1ffc, 32'hcafe_f00d, 4'hf,    RESP_OKAY};  // last word
    rows[6]  = '{1'b0, 4'd7,  32'h1ffc, 32'h0,         4'h0,    RESP_OKAY};
    rows[7]  = '{1'b1, 4'd8,  32'h2010, 32'hffff_ffff, 4'hf,    RESP_SLVERR};
    rows[8]  = '{1'b0, 4'd9,  32'h2010, 32'h0,         4'h0,    RESP_SLVERR};
    rows[9]  = '{1'b0, 4'd10, 32'h1010, 32'h0,         4'h0,    RESP_OKAY};  // alias of 0x2010
    rows[10] = '{1'b0, 4'd11, 32'h0ff0, 32'h0,         4'h0,    RESP_SLVERR};
    rows[11] = '{1'b1, 4'd12, 32'h1020, 32'h0bad_f00d, 4'hf,    RESP_OKAY};
    rows[12] = '{1'b1, 4'd13, 32'h1020, 32'h1234_5678, 4'b1001, RESP_OKAY};
    rows[13] = '{1'b0, 4'd14, 32'h1020, 32'h0,         4'h0,    RESP_OKAY};
    rows[14] = '{1'b0, 4'd15, 32'h1ffc, 32'h0,         4'h0,    RESP_OKAY};
    rows[15] = '{1'b0, 4'd0,  32'h1014, 32'h0,         4'h0,    RESP_OKAY};

    repeat (4) @(posedge clk);
    arst_n <= 1'b1;
    @(posedge clk);
    compare("b_valid", 64'(resp.b_valid), 64'(1'b0));
    compare("r_valid", 64'(resp.r_valid), 64'(1'b0));
    compare("aw_ready", 64'(resp.aw_ready), 64'(1'b1));
    compare("w_ready", 64'(resp.w_ready), 64'(1'b1));
    compare("ar_ready", 64'(resp.ar_ready), 64'(1'b1));

    for (int i = 0; i < N_ROWS && !abort; i++) begin
      if (rows[i].wr) model_write(rows[i]);
      exp_data = model_read(rows[i].addr);
      send_req(rows[i]);
      if (!abort) wait_resp(rows[i], exp_data);
    end

    assert_fails = i_dut.i_assert.fail_cnt;
    $display("%0d checks, %0d errors, %0d assertion failures", chk_cnt, err_cnt, assert_fails);
    if (err_cnt == 0 && assert_fails == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- src.f
common/axi_ram_pkg.sv
hdl/chan_fifo.sv
hdl/mem_bank.sv
axi_to_mem/axi_to_mem.sv
hdl/axi_ram.sv
bench/axi_ram_assert.sv
bench/tb_axi_ram.sv

//--- run.sh
#!/usr/bin/env bash
# compile and run tb_axi_ram with Verilator, verdict taken from sim.log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module tb_axi_ram \
  || { echo "verilator build failed"; exit 1; }

./obj_dir/Vtb_axi_ram > sim.log 2>&1 \
  || { cat sim.log; echo "simulation aborted"; exit 1; }

cat sim.log
grep -q "TEST FAILED" sim.log && { echo "simulation reported a failure"; exit 1; }
grep -q "TEST OK" sim.log || { echo "simulation ended without a verdict"; exit 1; }
exit 0
